//--- files.f
hw/regfile_pkg.sv
hw/regfile_dbg_if.sv
hw/regfile_ram_bank.sv
hw/regfile_lvt.sv
hw/regfile_fpga.sv
hw/regfile_wb_slave.sv
hw/regfile_top.sv
verification/regfile_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wall
TOP      = regfile_tb
FILELIST = files.f
PASS_MSG = Test completed successfully

SOURCES  = $(shell cat $(FILELIST))
SIM      = obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the simulation prints the pass message
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- verification/regfile_tb.sv
/*
 * Testbench for the multi-ported register file.
 * Clock and reset, commit and Wishbone drivers, a shadow reference
 * model, the compare process and a watchdog.
 */

`default_nettype none

module regfile_tb import regfile_pkg::*; ();

  // random phase length and a margin for the directed tests
  localparam int RAND_CYCLES = 2000;
  localparam int TEST_CYCLES = RAND_CYCLES + 100;

  logic                             clk;
  logic                             rst_n;
  reg_addr_t [NR_COMMIT_PORTS-1:0]  waddr;
  reg_data_t [NR_COMMIT_PORTS-1:0]  wdata;
  logic      [NR_COMMIT_PORTS-1:0]  we;
  reg_addr_t [NR_OPERAND_PORTS-1:0] raddr;
  reg_data_t [NR_OPERAND_PORTS-1:0] rdata;
  logic                             wb_cyc;
  logic                             wb_stb;
  logic                             wb_we;
  logic [31:0]                      wb_adr;
  reg_data_t                        wb_dat_w;
  reg_data_t                        wb_dat_r;
  logic                             wb_ack;

  // shadow copy of the registers
  reg_data_t shadow [NUM_WORDS];
  logic      valid  [NUM_WORDS];

  // bus tracking and error counts of the compare process
  int        data_errs;
  int        bus_errs;
  logic      busy;
  logic      hold;
  logic      ack_prev;
  logic      cur_we;
  logic      cur_chk;
  reg_data_t cur_exp;
  int        lat;

  integer seed;
  logic   rand_done;

  regfile_top DUT (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .waddr_i  (waddr),
    .wdata_i  (wdata),
    .we_i     (we),
    .raddr_i  (raddr),
    .rdata_o  (rdata),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  // expected read value with x0 hardwired to zero
  function automatic reg_data_t ref_value(reg_addr_t a);
    return (a == '0) ? '0 : shadow[a];
  endfunction

  // unwritten registers hold no defined value
  function automatic logic is_known(reg_addr_t a);
    return (a == '0) || valid[a];
  endfunction

  // one clock edge of writes in port order so that the last writer wins
  function automatic void ref_apply(logic dbg_we, reg_addr_t dbg_a, reg_data_t dbg_d);
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      if (we[p]) begin
        shadow[waddr[p]] = wdata[p];
        valid[waddr[p]]  = 1'b1;
      end
    end
    if (dbg_we) begin
      shadow[dbg_a] = dbg_d;
      valid[dbg_a]  = 1'b1;
    end
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic set_reads(reg_addr_t a0, reg_addr_t a1);
    raddr[0] = a0;
    raddr[1] = a1;
  endtask

  task automatic drive_commit(int p, reg_addr_t a, reg_data_t d);
    we[p]    = 1'b1;
    waddr[p] = a;
    wdata[p] = d;
  endtask

  // single classic cycle held until ack and released after the ack edge
  task automatic wb_access(logic w, reg_addr_t a, reg_data_t d);
    int n;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = w;
    wb_adr   = {25'd0, a, 2'b00};
    wb_dat_w = d;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < 6);
    next_cycle();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #((TEST_CYCLES + 200) * 10);
    $display("watchdog expired after %0d cycles, the run did not finish", TEST_CYCLES + 200);
    $display("Test failed");
    $finish;
  end

  // compare process sampling at the falling edge where all is stable
  initial begin
    logic dbg_wr;
    data_errs = 0;
    bus_errs  = 0;
    busy      = 1'b0;
    hold      = 1'b0;
    ack_prev  = 1'b0;
    cur_we    = 1'b0;
    cur_chk   = 1'b0;
    cur_exp   = '0;
    lat       = 0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      shadow[i] = '0;
      valid[i]  = 1'b0;
    end
    forever begin
      @(negedge clk);
      for (int p = 0; p < NR_OPERAND_PORTS; p++) begin
        if (is_known(raddr[p])) begin
          assert (rdata[p] == ref_value(raddr[p])) else begin
            $display("[FAIL] %0t operand port %0d reg %0d read %h, expected %h",
                     $time, p, raddr[p], rdata[p], ref_value(raddr[p]));
            data_errs++;
          end
        end
      end
      assert (!(wb_ack && ack_prev)) else begin
        $display("bus error at %0t: ack high in two consecutive cycles", $time);
        bus_errs++;
      end
      dbg_wr = 1'b0;
      if (busy) begin
        lat++;
        if (wb_ack) begin
          assert (lat == 2) else begin
            $display("[FAIL] %0t ack after %0d cycles, expected 2", $time, lat);
            data_errs++;
          end
          if (!cur_we && cur_chk) begin
            assert (wb_dat_r == cur_exp) else begin
              $display("[FAIL] %0t wishbone read %h, expected %h", $time, wb_dat_r, cur_exp);
              data_errs++;
            end
          end
          // debug write commits at the edge that ends the ack cycle
          dbg_wr = cur_we;
          busy   = 1'b0;
        end else begin
          assert (lat < 4) else begin
            $display("bus error at %0t: no ack within 4 cycles", $time);
            bus_errs++;
            busy = 1'b0;
            hold = 1'b1;
          end
        end
      end else begin
        assert (!wb_ack) else begin
          $display("bus error at %0t: ack without a pending access", $time);
          bus_errs++;
        end
      end
      if (!(wb_cyc && wb_stb)) begin
        hold = 1'b0;
      end
      // access starts at the coming edge and reads the value from before it
      if (!busy && !hold && wb_cyc && wb_stb && !wb_ack) begin
        busy    = 1'b1;
        lat     = 1;
        cur_we  = wb_we;
        cur_chk = is_known(wb_adr[6:2]);
        cur_exp = ref_value(wb_adr[6:2]);
      end
      ref_apply(dbg_wr, wb_adr[6:2], wb_dat_w);
      ack_prev = wb_ack;
    end
  end

  initial begin
    seed      = 32'hc329_90a3;
    rand_done = 1'b0;
    rst_n     = 1'b0;
    we        = '0;
    waddr     = '0;
    wdata     = '0;
    raddr     = '0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();

    // commit write on each port read back on both operand ports
    set_reads(5'd5, 5'd5);
    drive_commit(0, 5'd5, 32'h1111_0005);
    next_cycle();
    we = '0;
    next_cycle();
    set_reads(5'd6, 5'd6);
    drive_commit(1, 5'd6, 32'h2222_0006);
    next_cycle();
    we = '0;
    next_cycle();

    // same register from both ports and then from port 0 alone
    set_reads(5'd7, 5'd7);
    drive_commit(0, 5'd7, 32'haaaa_0007);
    drive_commit(1, 5'd7, 32'hbbbb_0007);
    next_cycle();
    we = '0;
    next_cycle();
    drive_commit(0, 5'd7, 32'hcccc_0007);
    next_cycle();
    we = '0;
    next_cycle();

    // x0 written from both sides still reads zero
    set_reads(5'd0, 5'd0);
    drive_commit(1, 5'd0, 32'hdead_beef);
    next_cycle();
    we = '0;
    wb_access(1'b1, 5'd0, 32'hfeed_f00d);
    wb_access(1'b0, 5'd0, '0);

    // debug write and a commit write landing on the same edge
    set_reads(5'd9, 5'd10);
    wb_access(1'b1, 5'd10, 32'h0bad_0010);
    fork
      wb_access(1'b1, 5'd9, 32'hd0d0_0009);
      begin
        next_cycle();
        drive_commit(0, 5'd9, 32'h5555_0009);
        next_cycle();
        we = '0;
      end
    join
    next_cycle();

    // read sees the value before a write on its start edge
    set_reads(5'd11, 5'd11);
    drive_commit(0, 5'd11, 32'h1234_0011);
    next_cycle();
    drive_commit(0, 5'd11, 32'h5678_0011);
    fork
      wb_access(1'b0, 5'd11, '0);
      begin
        next_cycle();
        we = '0;
      end
    join
    wb_access(1'b0, 5'd11, '0);

    // random commit and operand traffic with bus accesses in between
    fork
      begin
        repeat (RAND_CYCLES) begin
          for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            we[p]    = 1'($random(seed));
            waddr[p] = reg_addr_t'($random(seed));
            wdata[p] = reg_data_t'($random(seed));
          end
          for (int p = 0; p < NR_OPERAND_PORTS; p++) begin
            raddr[p] = reg_addr_t'($random(seed));
          end
          next_cycle();
        end
        we        = '0;
        rand_done = 1'b1;
      end
      while (!rand_done) begin
        repeat (2'($random(seed))) next_cycle();
        if (!rand_done) begin
          wb_access(1'($random(seed)), reg_addr_t'($random(seed)),
                    reg_data_t'($random(seed)));
        end
      end
    join

    repeat (3) next_cycle();
    $display("errors: %0d data, %0d bus", data_errs, bus_errs);
    if (data_errs == 0 && bus_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/regfile_top.sv
/*
 * Register file top level.
 * Plain commit, operand and Wishbone ports, with the Wishbone slave
 * joined to the core through the debug interface.
 */

`default_nettype none

module regfile_top import regfile_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // commit write ports
  input  reg_addr_t [NR_COMMIT_PORTS-1:0]   waddr_i,
  input  reg_data_t [NR_COMMIT_PORTS-1:0]   wdata_i,
  input  logic      [NR_COMMIT_PORTS-1:0]   we_i,
  // operand read ports
  input  reg_addr_t [NR_OPERAND_PORTS-1:0]  raddr_i,
  output reg_data_t [NR_OPERAND_PORTS-1:0]  rdata_o,
  // Wishbone classic debug slave
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [31:0]                       wb_adr_i,
  input  logic [DATA_WIDTH-1:0]             wb_dat_i,
  output logic [DATA_WIDTH-1:0]             wb_dat_o,
  output logic                              wb_ack_o
);

  // debug port between bus slave and core
  regfile_dbg_if dbg_if ();

  regfile_wb_slave i_wb_slave (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .dbg      (dbg_if.master)
  );

  regfile_fpga i_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .waddr_i (waddr_i),
    .wdata_i (wdata_i),
    .we_i    (we_i),
    .raddr_i (raddr_i),
    .rdata_o (rdata_o),
    .dbg     (dbg_if.slave)
  );

endmodule

`default_nettype wire

//--- hw/regfile_wb_slave.sv
/*
 * Wishbone classic debug slave.
 * Turns single bus cycles into debug reads and writes of the register
 * file, with a registered one-cycle ack.
 */

`default_nettype none

module regfile_wb_slave import regfile_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Wishbone classic slave
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [31:0]           wb_adr_i,
  input  logic [DATA_WIDTH-1:0] wb_dat_i,
  output logic [DATA_WIDTH-1:0] wb_dat_o,
  output logic                  wb_ack_o,
  // debug port towards the core
  regfile_dbg_if.master         dbg
);

  // word address of the register, byte offset below it
  localparam int unsigned REG_LSB = 2;
  localparam int unsigned REG_MSB = REG_LSB + ADDR_WIDTH - 1;

  logic      start;
  logic      hit;
  logic      ack_q;
  logic      we_q;
  reg_data_t dat_q;

  // new access: request present and not already being acked
  // so the slave never acks two cycles in a row
  assign start = wb_cyc_i && wb_stb_i && !ack_q;

  // only word-aligned accesses inside the register window hit
  // anything else is acked, writes are dropped and reads return zero
  assign hit = (wb_adr_i[31:REG_MSB+1] == '0) && (wb_adr_i[REG_LSB-1:0] == '0);

  // ack and write strobe, both high for exactly the ack cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      we_q  <= 1'b0;
    end else begin
      ack_q <= start;
      we_q  <= start && wb_we_i && hit;
    end
  end

  // read data sampled at the start edge
  // gives the value from before any write of this cycle
  always_ff @(posedge clk_i) begin
    if (start && !wb_we_i) begin
      dat_q <= hit ? dbg.dbg_rdata : '0;
    end
  end

  // master holds address and data until ack,
  // so the bus can feed the debug port directly
  assign dbg.dbg_raddr = wb_adr_i[REG_MSB:REG_LSB];
  assign dbg.dbg_waddr = wb_adr_i[REG_MSB:REG_LSB];
  assign dbg.dbg_wdata = wb_dat_i;
  // register updates at the edge that ends the ack cycle
  assign dbg.dbg_we    = we_q;

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

endmodule

`default_nettype wire

//--- hw/regfile_fpga.sv
/*
 * FPGA register file core.
 * One RAM bank per write port, the LVT, the output multiplexer and
 * the x0 masking. The debug port sits at index DBG_PORT.
 */

`default_nettype none

module regfile_fpga import regfile_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // commit write ports
  input  reg_addr_t [NR_COMMIT_PORTS-1:0]   waddr_i,
  input  reg_data_t [NR_COMMIT_PORTS-1:0]   wdata_i,
  input  logic      [NR_COMMIT_PORTS-1:0]   we_i,
  // operand read ports
  input  reg_addr_t [NR_OPERAND_PORTS-1:0]  raddr_i,
  output reg_data_t [NR_OPERAND_PORTS-1:0]  rdata_o,
  // debug read and write port
  regfile_dbg_if.slave                      dbg
);

  // merged port arrays, commit/operand first, debug on top
  logic      [NR_WRITE_PORTS-1:0] we_all;
  reg_addr_t [NR_WRITE_PORTS-1:0] waddr_all;
  reg_data_t [NR_WRITE_PORTS-1:0] wdata_all;
  reg_addr_t [NR_READ_PORTS-1:0]  raddr_all;
  reg_data_t [NR_READ_PORTS-1:0]  rdata_all;

  // bank outputs, one set of read ports per bank
  reg_data_t [NR_READ_PORTS-1:0]  bank_rdata [NR_WRITE_PORTS];
  bank_sel_t [NR_READ_PORTS-1:0]  bank_sel;

  for (genvar j = 0; j < NR_COMMIT_PORTS; j++) begin : gen_commit
    assign we_all[j]    = we_i[j];
    assign waddr_all[j] = waddr_i[j];
    assign wdata_all[j] = wdata_i[j];
  end
  assign we_all[DBG_PORT]    = dbg.dbg_we;
  assign waddr_all[DBG_PORT] = dbg.dbg_waddr;
  assign wdata_all[DBG_PORT] = dbg.dbg_wdata;

  for (genvar k = 0; k < NR_OPERAND_PORTS; k++) begin : gen_operand
    assign raddr_all[k] = raddr_i[k];
    assign rdata_o[k]   = rdata_all[k];
  end
  assign raddr_all[DBG_PORT] = dbg.dbg_raddr;
  assign dbg.dbg_rdata       = rdata_all[DBG_PORT];

  // one bank per write port
  for (genvar j = 0; j < NR_WRITE_PORTS; j++) begin : gen_bank
    regfile_ram_bank i_bank (
      .clk_i   (clk_i),
      .we_i    (we_all[j]),
      .waddr_i (waddr_all[j]),
      .wdata_i (wdata_all[j]),
      .raddr_i (raddr_all),
      .rdata_o (bank_rdata[j])
    );
  end

  regfile_lvt i_lvt (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .we_i       (we_all),
    .waddr_i    (waddr_all),
    .raddr_i    (raddr_all),
    .bank_sel_o (bank_sel)
  );

  // output mux, pick the bank named by the LVT
  // x0 always reads zero whatever was stored
  always_comb begin
    rdata_all = '0;
    for (int k = 0; k < NR_READ_PORTS; k++) begin
      for (int j = 0; j < NR_WRITE_PORTS; j++) begin
        if (bank_sel[k] == bank_sel_t'(j)) begin
          rdata_all[k] = bank_rdata[j][k];
        end
      end
      if (raddr_all[k] == '0) begin
        rdata_all[k] = '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/regfile_lvt.sv
/*
 * Live value table.
 * Decodes the write addresses, tracks per register which bank holds
 * the latest value (highest port index wins) and looks up the bank
 * for every read port.
 */

`default_nettype none

module regfile_lvt import regfile_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // write side, one entry per bank
  input  logic      [NR_WRITE_PORTS-1:0] we_i,
  input  reg_addr_t [NR_WRITE_PORTS-1:0] waddr_i,
  // read side
  input  reg_addr_t [NR_READ_PORTS-1:0]  raddr_i,
  output bank_sel_t [NR_READ_PORTS-1:0]  bank_sel_o
);

  // per port one-hot register enables
  logic [NR_WRITE_PORTS-1:0][NUM_WORDS-1:0] we_dec;
  // next and current bank selector per register
  bank_sel_t [NUM_WORDS-1:0] sel_d;
  bank_sel_t [NUM_WORDS-1:0] sel_q;

  // write address decode
  always_comb begin
    for (int j = 0; j < NR_WRITE_PORTS; j++) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        we_dec[j][i] = we_i[j] && (waddr_i[j] == reg_addr_t'(i));
      end
    end
  end

  // selector update
  // ports are scanned in rising order so the last hit,
  // i.e. the highest index, sets the selector
  always_comb begin
    sel_d = sel_q;
    for (int i = 0; i < NUM_WORDS; i++) begin
      for (int j = 0; j < NR_WRITE_PORTS; j++) begin
        if (we_dec[j][i]) begin
          sel_d[i] = bank_sel_t'(j);
        end
      end
    end
  end

  // selector flops, all registers point to bank 0 after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel_d;
    end
  end

  // bank lookup per read port
  // uses the registered table so a same-cycle write is not bypassed
  for (genvar k = 0; k < NR_READ_PORTS; k++) begin : gen_lookup
    assign bank_sel_o[k] = sel_q[raddr_i[k]];
  end

endmodule

`default_nettype wire

//--- hw/regfile_ram_bank.sv
/*
 * Register file RAM bank.
 * 32-word memory with one synchronous write port and an async read
 * port per register file read port, mapping to distributed RAM.
 */

`default_nettype none

module regfile_ram_bank import regfile_pkg::*; (
  input  logic                          clk_i,
  // write port owned by this bank
  input  logic                          we_i,
  input  reg_addr_t                     waddr_i,
  input  reg_data_t                     wdata_i,
  // every read port of the register file
  input  reg_addr_t [NR_READ_PORTS-1:0] raddr_i,
  output reg_data_t [NR_READ_PORTS-1:0] rdata_o
);

  // storage array, contents undefined until written
  reg_data_t mem [NUM_WORDS];

  // single write port
  // x0 is stored like any other word, the core masks it on read
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // async reads, one LUT-RAM read port each
  for (genvar k = 0; k < NR_READ_PORTS; k++) begin : gen_read
    assign rdata_o[k] = mem[raddr_i[k]];
  end

endmodule

`default_nettype wire

//--- hw/regfile_dbg_if.sv
/*
 * Debug port interface.
 * One write and one read port of the register file, driven by the
 * Wishbone slave (master side) and served by the core (slave side).
 */

`default_nettype none

interface regfile_dbg_if import regfile_pkg::*; ();

  // write port
  reg_addr_t dbg_waddr;
  reg_data_t dbg_wdata;
  logic      dbg_we;
  // read port, combinational in the core
  reg_addr_t dbg_raddr;
  reg_data_t dbg_rdata;

  modport master (
    output dbg_waddr,
    output dbg_wdata,
    output dbg_we,
    output dbg_raddr,
    input  dbg_rdata
  );

  modport slave (
    input  dbg_waddr,
    input  dbg_wdata,
    input  dbg_we,
    input  dbg_raddr,
    output dbg_rdata
  );

endinterface

`default_nettype wire

//--- hw/regfile_pkg.sv
/*
 * Register file package.
 * Sizes of the multi-ported register file, the port counts and the
 * index of the debug port, plus the address, data and bank types.
 */

`default_nettype none

package regfile_pkg;

  // register geometry
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ADDR_WIDTH = 5;
  localparam int unsigned NUM_WORDS  = 2 ** ADDR_WIDTH;

  // external ports seen by the pipeline
  localparam int unsigned NR_COMMIT_PORTS  = 2;
  localparam int unsigned NR_OPERAND_PORTS = 2;

  // debug port is appended after the external ports on both sides
  localparam int unsigned NR_WRITE_PORTS = NR_COMMIT_PORTS + 1;
  localparam int unsigned NR_READ_PORTS  = NR_OPERAND_PORTS + 1;

  // highest index, so a debug write wins any same-cycle conflict
  localparam int unsigned DBG_PORT = 2;

  // enough bits to name any write bank
  localparam int unsigned BANK_SEL_WIDTH = 2;

  typedef logic [ADDR_WIDTH-1:0]     reg_addr_t;
  typedef logic [DATA_WIDTH-1:0]     reg_data_t;
  typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;

endpackage

`default_nettype wire
